// File: verilog/bridge_defs.svh
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// bus widths
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32 // one axi beat
`define BRIDGE_LINE_W 128 // one cache line

// burst shape
`define BRIDGE_LINE_BEATS 4 // words per line
`define BRIDGE_LEN_W 8 // axi len field
`define BRIDGE_ID_W 4

// cache request type
`define BRIDGE_TYPE_W 3
`define BRIDGE_TYPE_LINE_BIT 2 // set for a whole-line request

`endif

// File: verilog/bridge_pkg.sv
`include "bridge_defs.svh"

package bridge_pkg;

    // cache read request, shared by icache and dcache
    typedef struct packed {
        logic                      req;
        logic [`BRIDGE_TYPE_W-1:0] req_type;
        logic [`BRIDGE_ADDR_W-1:0] addr;
    } cache_rd_req_t;

    typedef struct packed {
        logic                      valid;
        logic                      last; // final word of the burst
        logic [`BRIDGE_DATA_W-1:0] data;
    } cache_rd_ret_t;

    // dcache write, word or full line
    typedef struct packed {
        logic                        req;
        logic [`BRIDGE_TYPE_W-1:0]   req_type;
        logic [`BRIDGE_ADDR_W-1:0]   addr;
        logic [`BRIDGE_DATA_W/8-1:0] wstrb;
        logic [`BRIDGE_LINE_W-1:0]   data; // word 0 in the low bits
    } cache_wr_req_t;

    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]   id;
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [`BRIDGE_LEN_W-1:0]  len;
        logic                      valid;
    } axi_ar_t;

    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]   id; // bit 0 picks the cache
        logic [`BRIDGE_DATA_W-1:0] data;
        logic                      last;
        logic                      valid;
    } axi_r_t;

    typedef struct packed {
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [`BRIDGE_LEN_W-1:0]  len;
        logic                      valid;
    } axi_aw_t;

    typedef struct packed {
        logic [`BRIDGE_DATA_W-1:0]   data;
        logic [`BRIDGE_DATA_W/8-1:0] strb;
        logic                        last;
        logic                        valid;
    } axi_w_t;

    typedef struct packed {
        logic valid; // resp ignored
    } axi_b_t;

endpackage

// File: verilog/bridge_ctrl.sv
module bridge_ctrl (
    input  logic aclk,
    input  logic areset,
    input  logic dcache_rd_req,
    input  logic icache_rd_req,
    input  logic rd_hazard,     // read addr matches captured write addr
    input  logic wr_req,
    input  logic ar_ready,
    input  logic r_beat_done,   // last r beat accepted
    input  logic aw_ready,
    input  logic w_beat_fire,
    input  logic w_last_beat,
    input  logic b_valid,
    output logic rd_load,
    output logic wr_load,
    output logic ar_valid,
    output logic r_ready,
    output logic aw_valid,
    output logic w_valid,
    output logic b_ready,
    output logic icache_rd_rdy,
    output logic dcache_rd_rdy,
    output logic wr_rdy,
    output logic wr_busy
);

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;
    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ADDR_DATA, // aw and w both pending
        WR_ADDR_ONLY, // w done, aw pending
        WR_DATA_ONLY, // aw done, w pending
        WR_RESP
    } wr_state_t;

    rd_state_t rd_state;
    rd_state_t rd_next;
    wr_state_t wr_state;
    wr_state_t wr_next;
    logic      hazard;
    logic      aw_fire;
    logic      w_done;

    // raw check only counts while a write is outstanding
    assign hazard        = rd_hazard & wr_busy;
    assign dcache_rd_rdy = (rd_state == RD_IDLE) & ~hazard;
    assign icache_rd_rdy = dcache_rd_rdy & ~dcache_rd_req; // dcache wins
    assign rd_load       = (dcache_rd_req & dcache_rd_rdy) | (icache_rd_req & icache_rd_rdy);

    assign ar_valid = (rd_state == RD_ADDR);
    assign r_ready  = (rd_state == RD_DATA);

    always_ff @(posedge aclk) begin
        if (areset) begin
            rd_state <= RD_IDLE;
        end else begin
            rd_state <= rd_next;
        end
    end

    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_IDLE: if (rd_load) rd_next = RD_ADDR;
            RD_ADDR: if (ar_ready) rd_next = RD_DATA; // arvalid is high here
            RD_DATA: if (r_beat_done) rd_next = RD_IDLE;
            default: rd_next = RD_IDLE;
        endcase
    end

    // write side
    assign wr_rdy   = (wr_state == WR_IDLE);
    assign wr_load  = wr_req & wr_rdy;
    assign wr_busy  = ~wr_rdy; // acceptance through b handshake
    assign aw_valid = (wr_state == WR_ADDR_DATA) | (wr_state == WR_ADDR_ONLY);
    assign w_valid  = (wr_state == WR_ADDR_DATA) | (wr_state == WR_DATA_ONLY);
    assign b_ready  = (wr_state == WR_RESP);
    assign aw_fire  = aw_valid & aw_ready;
    assign w_done   = w_beat_fire & w_last_beat;

    always_ff @(posedge aclk) begin
        if (areset) begin
            wr_state <= WR_IDLE;
        end else begin
            wr_state <= wr_next;
        end
    end

    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            WR_IDLE: if (wr_load) wr_next = WR_ADDR_DATA;
            WR_ADDR_DATA: begin
                if (aw_fire && w_done) begin
                    wr_next = WR_RESP;
                end else if (aw_fire) begin
                    wr_next = WR_DATA_ONLY;
                end else if (w_done) begin
                    wr_next = WR_ADDR_ONLY;
                end
            end
            WR_ADDR_ONLY: if (aw_fire) wr_next = WR_RESP;
            WR_DATA_ONLY: if (w_done) wr_next = WR_RESP;
            WR_RESP:      if (b_valid) wr_next = WR_IDLE; // bready high in this state
            default:      wr_next = WR_IDLE;
        endcase
    end

endmodule

// File: verilog/read_path.sv
`include "bridge_defs.svh"

module read_path (
    input  logic                      aclk,
    input  logic                      areset,
    input  logic                      rd_load,
    input  bridge_pkg::cache_rd_req_t icache_req,
    input  bridge_pkg::cache_rd_req_t dcache_req,
    input  logic [`BRIDGE_ADDR_W-1:0] wr_addr,     // captured write address
    input  logic                      ar_valid,
    input  bridge_pkg::axi_r_t        r,
    input  logic                      r_ready,
    output bridge_pkg::axi_ar_t       ar,
    output logic                      rd_hazard,
    output bridge_pkg::cache_rd_ret_t icache_ret,
    output bridge_pkg::cache_rd_ret_t dcache_ret
);

    bridge_pkg::cache_rd_req_t cand; // request that would be taken this cycle
    logic                      cand_is_d;
    logic                      cand_line;
    logic [`BRIDGE_ID_W-1:0]   ar_id_q;
    logic [`BRIDGE_ADDR_W-1:0] ar_addr_q;
    logic [`BRIDGE_LEN_W-1:0]  ar_len_q;
    logic                      r_beat;

    assign cand_is_d = dcache_req.req; // dcache first
    assign cand      = cand_is_d ? dcache_req : icache_req;
    assign cand_line = cand.req_type[`BRIDGE_TYPE_LINE_BIT];
    assign rd_hazard = (cand.addr == wr_addr);

    always_ff @(posedge aclk) begin
        if (areset) begin
            ar_id_q  <= '0;
            ar_len_q <= '0;
        end else if (rd_load) begin
            ar_id_q  <= {{(`BRIDGE_ID_W-1){1'b0}}, cand_is_d};
            ar_len_q <= cand_line ? `BRIDGE_LEN_W'(`BRIDGE_LINE_BEATS - 1) : '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_load) ar_addr_q <= cand.addr;
    end

    assign ar.id    = ar_id_q;
    assign ar.addr  = ar_addr_q;
    assign ar.len   = ar_len_q;
    assign ar.valid = ar_valid;

    // returns pass straight through, steered by id bit 0
    assign r_beat = r.valid & r_ready;

    assign icache_ret.valid = r_beat & ~r.id[0];
    assign icache_ret.last  = r_beat & ~r.id[0] & r.last;
    assign icache_ret.data  = r.data;

    assign dcache_ret.valid = r_beat & r.id[0];
    assign dcache_ret.last  = r_beat & r.id[0] & r.last;
    assign dcache_ret.data  = r.data;

endmodule

// File: verilog/write_path.sv
`include "bridge_defs.svh"

module write_path (
    input  logic                      aclk,
    input  logic                      areset,
    input  logic                      wr_load,
    input  bridge_pkg::cache_wr_req_t wr_req,
    input  logic                      aw_valid,
    input  logic                      w_valid,
    input  logic                      w_ready,
    output bridge_pkg::axi_aw_t       aw,
    output bridge_pkg::axi_w_t        w,
    output logic [`BRIDGE_ADDR_W-1:0] wr_addr,
    output logic                      w_beat_fire,
    output logic                      w_last_beat
);

    localparam int CNT_W = $clog2(`BRIDGE_LINE_BEATS);

    logic                        req_line;
    logic [`BRIDGE_ADDR_W-1:0]   aw_addr_q;
    logic [`BRIDGE_LEN_W-1:0]    aw_len_q;
    logic [`BRIDGE_DATA_W/8-1:0] strb_q;
    logic [`BRIDGE_LINE_W-1:0]   line_q;   // next word always in the low bits
    logic [CNT_W-1:0]            beat_cnt; // beats left after the current one

    assign req_line = wr_req.req_type[`BRIDGE_TYPE_LINE_BIT];

    // payload, held until the burst is out
    always_ff @(posedge aclk) begin
        if (wr_load) begin
            aw_addr_q <= wr_req.addr;
            aw_len_q  <= req_line ? `BRIDGE_LEN_W'(`BRIDGE_LINE_BEATS - 1) : '0;
            strb_q    <= wr_req.wstrb;
            line_q    <= wr_req.data;
        end else if (w_beat_fire) begin
            line_q <= {{`BRIDGE_DATA_W{1'b0}}, line_q[`BRIDGE_LINE_W-1:`BRIDGE_DATA_W]};
        end
    end

    always_ff @(posedge aclk) begin
        if (areset) begin
            beat_cnt <= '0;
        end else if (wr_load) begin
            beat_cnt <= req_line ? CNT_W'(`BRIDGE_LINE_BEATS - 1) : '0; // same as len
        end else if (w_beat_fire) begin
            beat_cnt <= beat_cnt - 1'b1;
        end
    end

    assign w_beat_fire = w_valid & w_ready;
    assign w_last_beat = (beat_cnt == '0);
    assign wr_addr     = aw_addr_q; // for the raw compare

    assign aw.addr  = aw_addr_q;
    assign aw.len   = aw_len_q;
    assign aw.valid = aw_valid;

    assign w.data  = line_q[`BRIDGE_DATA_W-1:0];
    assign w.strb  = strb_q; // same strobe on every beat
    assign w.last  = w_last_beat;
    assign w.valid = w_valid;

endmodule

// File: verilog/cache_axi_bridge.sv
`include "bridge_defs.svh"

module cache_axi_bridge (
    input  logic                      aclk,
    input  logic                      areset,
    input  bridge_pkg::cache_rd_req_t icache_rd_req,
    output logic                      icache_rd_rdy,
    output bridge_pkg::cache_rd_ret_t icache_ret,
    input  bridge_pkg::cache_rd_req_t dcache_rd_req,
    output logic                      dcache_rd_rdy,
    output bridge_pkg::cache_rd_ret_t dcache_ret,
    input  bridge_pkg::cache_wr_req_t dcache_wr_req,
    output logic                      dcache_wr_rdy,
    output bridge_pkg::axi_ar_t       ar,
    input  logic                      ar_ready,
    input  bridge_pkg::axi_r_t        r,
    output logic                      r_ready,
    output bridge_pkg::axi_aw_t       aw,
    input  logic                      aw_ready,
    output bridge_pkg::axi_w_t        w,
    input  logic                      w_ready,
    input  bridge_pkg::axi_b_t        b,
    output logic                      b_ready
);

    logic                      rd_load;
    logic                      wr_load;
    logic                      rd_hazard;
    logic                      ar_valid;
    logic                      aw_valid;
    logic                      w_valid;
    logic                      w_beat_fire;
    logic                      w_last_beat;
    logic                      r_beat_done;
    logic [`BRIDGE_ADDR_W-1:0] wr_addr;

    assign r_beat_done = r.valid & r_ready & r.last; // end of read burst

    bridge_ctrl u_ctrl (
        .aclk          (aclk),
        .areset        (areset),
        .dcache_rd_req (dcache_rd_req.req),
        .icache_rd_req (icache_rd_req.req),
        .rd_hazard     (rd_hazard),
        .wr_req        (dcache_wr_req.req),
        .ar_ready      (ar_ready),
        .r_beat_done   (r_beat_done),
        .aw_ready      (aw_ready),
        .w_beat_fire   (w_beat_fire),
        .w_last_beat   (w_last_beat),
        .b_valid       (b.valid),
        .rd_load       (rd_load),
        .wr_load       (wr_load),
        .ar_valid      (ar_valid),
        .r_ready       (r_ready),
        .aw_valid      (aw_valid),
        .w_valid       (w_valid),
        .b_ready       (b_ready),
        .icache_rd_rdy (icache_rd_rdy),
        .dcache_rd_rdy (dcache_rd_rdy),
        .wr_rdy        (dcache_wr_rdy),
        .wr_busy       ()              // status only, hazard gating is internal
    );

    read_path u_read_path (
        .aclk       (aclk),
        .areset     (areset),
        .rd_load    (rd_load),
        .icache_req (icache_rd_req),
        .dcache_req (dcache_rd_req),
        .wr_addr    (wr_addr),
        .ar_valid   (ar_valid),
        .r          (r),
        .r_ready    (r_ready),
        .ar         (ar),
        .rd_hazard  (rd_hazard),
        .icache_ret (icache_ret),
        .dcache_ret (dcache_ret)
    );

    write_path u_write_path (
        .aclk        (aclk),
        .areset      (areset),
        .wr_load     (wr_load),
        .wr_req      (dcache_wr_req),
        .aw_valid    (aw_valid),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .aw          (aw),
        .w           (w),
        .wr_addr     (wr_addr),
        .w_beat_fire (w_beat_fire),
        .w_last_beat (w_last_beat)
    );

endmodule

// File: verification/axi_slave_model.sv
module axi_slave_model #(
    parameter logic [31:0] DATA_KEY = 32'h0 // xor mask on read data
) (
    input  logic                aclk,
    input  logic                areset,
    input  logic                heavy,     // mostly stalled when set
    input  bridge_pkg::axi_ar_t ar,
    output logic                ar_ready,
    output bridge_pkg::axi_r_t  r,
    input  logic                r_ready,
    input  bridge_pkg::axi_aw_t aw,
    output logic                aw_ready,
    input  bridge_pkg::axi_w_t  w,
    output logic                w_ready,
    output bridge_pkg::axi_b_t  b,
    input  logic                b_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    integer              seed = 34;
    logic                rd_busy, r_valid_q, b_valid_q;
    logic                aw_got, w_got; // halves of the current write seen
    logic [3:0]          rd_id;
    logic [31:0]         rd_addr;
    logic [7:0]          rd_len, rd_beat;
    bridge_pkg::axi_aw_t aw_log [0:15]; // every accepted aw, in order
    bridge_pkg::axi_w_t  w_log [0:63];
    int                  aw_cnt, w_cnt;

    // one random draw, roughly 1 in 4 stalls, 3 in 4 when heavy
    function logic stall();
        stall = heavy ? (($random(seed) & 3) != 0) : (($random(seed) & 3) == 0);
    endfunction

    initial begin
        {ar_ready, aw_ready, w_ready, r_valid_q, b_valid_q} = '0;
        {rd_busy, aw_got, w_got, rd_id, rd_addr, rd_len, rd_beat} = '0;
    end

    // read side, one burst at a time
    always @(posedge aclk) begin
        if (areset) begin
            ar_ready  <= 1'b0;
            r_valid_q <= 1'b0;
            rd_busy   <= 1'b0;
        end else if (!rd_busy) begin
            if (ar.valid && ar_ready) begin
                rd_busy   <= 1'b1;
                rd_id     <= ar.id;
                rd_addr   <= ar.addr;
                rd_len    <= ar.len;
                rd_beat   <= '0;
                ar_ready  <= 1'b0;
                r_valid_q <= ~stall();
            end else begin
                ar_ready <= ~stall();
            end
        end else if (r_valid_q && r_ready) begin
            if (rd_beat == rd_len) begin
                rd_busy   <= 1'b0;
                r_valid_q <= 1'b0;
            end else begin
                rd_beat   <= rd_beat + 1'b1;
                r_valid_q <= ~stall();
            end
        end else if (!r_valid_q) begin
            r_valid_q <= ~stall(); // once up, held until taken
        end
    end

    assign r.id    = rd_id;
    assign r.data  = (rd_addr + {rd_beat, 2'b00}) ^ DATA_KEY; // beat k reads A + 4k
    assign r.last  = (rd_beat == rd_len);
    assign r.valid = r_valid_q;

    // write side, logs aw and w beats, answers b when both halves are in
    always @(posedge aclk) begin
        if (areset) begin
            {aw_ready, w_ready, b_valid_q, aw_got, w_got} <= '0;
            aw_cnt <= 0;
            w_cnt  <= 0;
        end else begin
            aw_ready <= ~stall();
            w_ready  <= ~stall();
            if (aw.valid && aw_ready) begin
                aw_log[aw_cnt] <= aw;
                aw_cnt         <= aw_cnt + 1;
                aw_got         <= 1'b1;
            end
            if (w.valid && w_ready) begin
                w_log[w_cnt] <= w;
                w_cnt        <= w_cnt + 1;
                if (w.last) w_got <= 1'b1;
            end
            if (b_valid_q && b_ready) begin
                b_valid_q <= 1'b0;
            end else if (aw_got && w_got && !b_valid_q && !stall()) begin
                b_valid_q <= 1'b1;
                aw_got    <= 1'b0;
                w_got     <= 1'b0;
            end
        end
    end

    assign b.valid = b_valid_q;

endmodule

// File: verification/tb_cache_axi_bridge.sv
`include "bridge_defs.svh"

module tb_cache_axi_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] DATA_KEY = 32'h5ca1_ab1e;
    localparam int          NUM_ROWS = 7;

    typedef struct packed {
        logic         is_wr;
        logic [1:0]   port;  // 0 icache, 1 dcache, 2 both
        logic [2:0]   rtype;
        logic [31:0]  addr;
        logic [127:0] line;
        logic [3:0]   strb;
        logic         post;  // next row starts without waiting
        logic         heavy; // slave stalls most cycles
    } row_t;

    logic                      aclk, areset, heavy;
    bridge_pkg::cache_rd_req_t icache_rd_req, dcache_rd_req;
    bridge_pkg::cache_wr_req_t dcache_wr_req;
    logic                      icache_rd_rdy, dcache_rd_rdy, dcache_wr_rdy;
    bridge_pkg::cache_rd_ret_t icache_ret, dcache_ret;
    bridge_pkg::axi_ar_t       ar, ar_prev;
    bridge_pkg::axi_r_t        r;
    bridge_pkg::axi_aw_t       aw, aw_prev;
    bridge_pkg::axi_w_t        w, w_prev;
    bridge_pkg::axi_b_t        b;
    logic                      ar_ready, r_ready, aw_ready, w_ready, b_ready;
    logic                      ar_held, aw_held, w_held;

    row_t                      rows [0:NUM_ROWS-1];
    bridge_pkg::axi_ar_t       exp_ar [$];
    int                        exp_min_b [$]; // b responses needed before that ar
    bridge_pkg::cache_rd_ret_t exp_iret [$], exp_dret [$];
    bridge_pkg::axi_aw_t       exp_aw [$];
    bridge_pkg::axi_w_t        exp_w [$];
    int                        b_cnt, wr_issued, aw_seen, w_seen;
    logic [31:0]               last_wr_addr;

    cache_axi_bridge u_dut (
        .aclk (aclk), .areset (areset),
        .icache_rd_req (icache_rd_req), .icache_rd_rdy (icache_rd_rdy), .icache_ret (icache_ret),
        .dcache_rd_req (dcache_rd_req), .dcache_rd_rdy (dcache_rd_rdy), .dcache_ret (dcache_ret),
        .dcache_wr_req (dcache_wr_req), .dcache_wr_rdy (dcache_wr_rdy),
        .ar (ar), .ar_ready (ar_ready), .r (r), .r_ready (r_ready),
        .aw (aw), .aw_ready (aw_ready), .w (w), .w_ready (w_ready),
        .b (b), .b_ready (b_ready)
    );

    axi_slave_model #(.DATA_KEY (DATA_KEY)) u_slave (
        .aclk (aclk), .areset (areset), .heavy (heavy),
        .ar (ar), .ar_ready (ar_ready), .r (r), .r_ready (r_ready),
        .aw (aw), .aw_ready (aw_ready), .w (w), .w_ready (w_ready),
        .b (b), .b_ready (b_ready)
    );

    always #4 aclk = ~aclk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_ar(input string name, input bridge_pkg::axi_ar_t exp,
                            input bridge_pkg::axi_ar_t act);
        if (act !== exp)
            abort_run($sformatf("** Error at %0d ns: %s expected %h actual %h",
                                $time, name, exp, act));
    endtask

    task automatic check_aw(input string name, input bridge_pkg::axi_aw_t exp,
                            input bridge_pkg::axi_aw_t act);
        if (act !== exp)
            abort_run($sformatf("** Error at %0d ns: %s expected %h actual %h",
                                $time, name, exp, act));
    endtask

    task automatic check_w(input string name, input bridge_pkg::axi_w_t exp,
                           input bridge_pkg::axi_w_t act);
        if (act !== exp)
            abort_run($sformatf("** Error at %0d ns: %s expected %h actual %h",
                                $time, name, exp, act));
    endtask

    task automatic check_ret(input string name, input bridge_pkg::cache_rd_ret_t exp,
                             input bridge_pkg::cache_rd_ret_t act);
        if (act !== exp)
            abort_run($sformatf("** Error at %0d ns: %s expected %h actual %h",
                                $time, name, exp, act));
    endtask

    // a read to the address of an unanswered write must wait for its b
    function automatic int needed_b(input logic [31:0] a);
        return (b_cnt < wr_issued && a == last_wr_addr) ? wr_issued : 0;
    endfunction

    task automatic expect_read(input logic is_d, input logic [2:0] t, input logic [31:0] a,
                               input int min_b);
        bridge_pkg::axi_ar_t       ar_e;
        bridge_pkg::cache_rd_ret_t ret_e;
        int                        len;
        len        = t[`BRIDGE_TYPE_LINE_BIT] ? `BRIDGE_LINE_BEATS - 1 : 0;
        ar_e.id    = {3'b000, is_d}; // id bit 0 marks the dcache
        ar_e.addr  = a;
        ar_e.len   = 8'(len);
        ar_e.valid = 1'b1;
        exp_ar.push_back(ar_e);
        exp_min_b.push_back(min_b);
        for (int k = 0; k <= len; k++) begin
            ret_e.valid = 1'b1;
            ret_e.last  = (k == len);
            ret_e.data  = (a + 32'(4 * k)) ^ DATA_KEY;
            if (is_d) exp_dret.push_back(ret_e);
            else exp_iret.push_back(ret_e);
        end
    endtask

    task automatic send_reads(input row_t rw);
        logic        d_on, i_on, d_fire, i_fire;
        logic [31:0] i_addr;
        int          d_min, i_min;
        d_on   = (rw.port != 2'd0);
        i_on   = (rw.port != 2'd1);
        i_addr = (rw.port == 2'd2) ? (rw.addr ^ 32'h100) : rw.addr; // own line when both
        while (!((!d_on || dcache_rd_rdy) && (!i_on || icache_rd_rdy))) @(negedge aclk);
        @(posedge aclk);
        #1;
        d_min = needed_b(rw.addr);
        i_min = needed_b(i_addr);
        if (d_on) dcache_rd_req = {1'b1, rw.rtype, rw.addr};
        if (i_on) icache_rd_req = {1'b1, rw.rtype, i_addr};
        while (d_on || i_on) begin
            @(negedge aclk);
            d_fire = d_on && dcache_rd_rdy; // taken at the coming edge
            i_fire = i_on && icache_rd_rdy;
            if (d_fire) expect_read(1'b1, rw.rtype, rw.addr, d_min);
            if (i_fire) expect_read(1'b0, rw.rtype, i_addr, i_min);
            @(posedge aclk);
            #1;
            if (d_fire) begin
                dcache_rd_req.req = 1'b0;
                d_on              = 1'b0;
            end
            if (i_fire) begin
                icache_rd_req.req = 1'b0;
                i_on              = 1'b0;
            end
        end
    endtask

    task automatic send_write(input row_t rw);
        bridge_pkg::axi_aw_t aw_e;
        bridge_pkg::axi_w_t  w_e;
        int                  len;
        while (!dcache_wr_rdy) @(negedge aclk);
        @(posedge aclk);
        #1;
        dcache_wr_req = {1'b1, rw.rtype, rw.addr, rw.strb, rw.line};
        @(negedge aclk);
        while (!dcache_wr_rdy) @(negedge aclk);
        @(posedge aclk);
        #1;
        dcache_wr_req.req = 1'b0;
        len        = rw.rtype[`BRIDGE_TYPE_LINE_BIT] ? `BRIDGE_LINE_BEATS - 1 : 0;
        aw_e.addr  = rw.addr;
        aw_e.len   = 8'(len);
        aw_e.valid = 1'b1;
        exp_aw.push_back(aw_e);
        for (int k = 0; k <= len; k++) begin
            w_e.data  = rw.line[32*k +: 32]; // lowest word first
            w_e.strb  = rw.strb;
            w_e.last  = (k == len);
            w_e.valid = 1'b1;
            exp_w.push_back(w_e);
        end
        wr_issued++;
        last_wr_addr = rw.addr;
    endtask

    // compare whatever the slave logged since the last call
    task automatic check_writes();
        while (aw_seen < u_slave.aw_cnt) begin
            if (exp_aw.size() == 0) abort_run("an AW transfer happened with no write outstanding");
            check_aw("aw", exp_aw.pop_front(), u_slave.aw_log[aw_seen]);
            aw_seen++;
        end
        while (w_seen < u_slave.w_cnt) begin
            if (exp_w.size() == 0) abort_run("a W beat arrived beyond the expected burst");
            check_w("w", exp_w.pop_front(), u_slave.w_log[w_seen]);
            w_seen++;
        end
        if (exp_aw.size() != 0 || exp_w.size() != 0)
            abort_run("a write completed with AW or W beats missing");
    endtask

    task automatic drain();
        while (exp_ar.size() != 0 || exp_iret.size() != 0 || exp_dret.size() != 0
               || !dcache_wr_rdy) @(negedge aclk);
        if (b_cnt != wr_issued) abort_run("write ready came back before the B response");
        check_writes();
    endtask

    // bus monitor sampled mid-cycle
    always @(negedge aclk) begin : monitor
        bridge_pkg::cache_rd_ret_t ret_e;
        if (!areset) begin
            if (b.valid && b_ready) b_cnt++;
            if (ar_held) check_ar("ar while stalled", ar_prev, ar);
            if (aw_held) check_aw("aw while stalled", aw_prev, aw);
            if (w_held) check_w("w while stalled", w_prev, w);
            if (ar.valid && ar_ready) begin
                if (exp_ar.size() == 0) abort_run("an AR transfer happened with no read pending");
                if (b_cnt < exp_min_b[0])
                    abort_run("a read went out before the write to its address was answered");
                check_ar("ar", exp_ar.pop_front(), ar);
                void'(exp_min_b.pop_front());
            end
            if (icache_ret.valid) begin
                if (exp_iret.size() == 0) abort_run("icache got return data it never asked for");
                ret_e = exp_iret.pop_front();
                check_ret("icache_ret", ret_e, icache_ret);
            end
            if (dcache_ret.valid) begin
                if (exp_dret.size() == 0) abort_run("dcache got return data it never asked for");
                ret_e = exp_dret.pop_front();
                check_ret("dcache_ret", ret_e, dcache_ret);
            end
            ar_held = ar.valid && !ar_ready;
            aw_held = aw.valid && !aw_ready;
            w_held  = w.valid && !w_ready;
            ar_prev = ar;
            aw_prev = aw;
            w_prev  = w;
        end
    end

    initial begin
        #(NUM_ROWS * 200 * 8);
        $display("timeout: the tests did not finish within %0d clock cycles", NUM_ROWS * 200);
        abort_run("the bridge stopped making progress");
    end

    initial begin
        aclk          = 1'b0;
        areset        = 1'b1;
        heavy         = 1'b0;
        icache_rd_req = '0;
        dcache_rd_req = '0;
        dcache_wr_req = '0;
        {ar_held, aw_held, w_held} = '0;
        {b_cnt, wr_issued, aw_seen, w_seen} = '0;
        last_wr_addr  = '0;
        // is_wr, port, type, addr, line, strb, post, heavy
        rows[0] = {1'b0, 2'd0, 3'b000, 32'h0000_1000, 128'h0, 4'h0, 1'b0, 1'b0};
        rows[1] = {1'b0, 2'd1, 3'b100, 32'h0000_2040, 128'h0, 4'h0, 1'b0, 1'b0};
        rows[2] = {1'b0, 2'd2, 3'b100, 32'h0000_3000, 128'h0, 4'h0, 1'b0, 1'b0};
        rows[3] = {1'b1, 2'd1, 3'b100, 32'h0000_4000,
                   128'hdddd0003_cccc0002_bbbb0001_aaaa0000, 4'hf, 1'b0, 1'b0};
        rows[4] = {1'b1, 2'd1, 3'b100, 32'h0000_5000,
                   128'h44440003_44440002_44440001_44440000, 4'hf, 1'b1, 1'b0};
        rows[5] = {1'b0, 2'd1, 3'b000, 32'h0000_5000, 128'h0, 4'h0, 1'b0, 1'b0}; // raw
        rows[6] = {1'b1, 2'd1, 3'b000, 32'h0000_6004, 128'h0000_5a5a_0606, 4'h3, 1'b0, 1'b1};
        repeat (16) @(posedge aclk);
        #1;
        areset = 1'b0;
        @(negedge aclk);
        if (!(icache_rd_rdy && dcache_rd_rdy && dcache_wr_rdy) || ar.valid || aw.valid
            || w.valid || r_ready || b_ready || icache_ret.valid || dcache_ret.valid)
            abort_run("bridge outputs were not idle after reset");
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge aclk);
            #1;
            heavy = rows[i].heavy;
            if (rows[i].is_wr) send_write(rows[i]);
            else send_reads(rows[i]);
            if (!rows[i].post) drain();
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
verilog/bridge_pkg.sv
verilog/bridge_ctrl.sv
verilog/read_path.sv
verilog/write_path.sv
verilog/cache_axi_bridge.sv
verification/axi_slave_model.sv
verification/tb_cache_axi_bridge.sv
